// ==== files.f ====
irq_pkg.sv
periph_bus_if.sv
irq_sync.sv
irq_timer.sv
plic.sv
mmio_bridge.sv
irq_subsystem.sv
tb_irq_subsystem.sv

// ==== Makefile ====
# Verilator build for the interrupt subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_irq_subsystem
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF "*** TEST PASSED ***" $(LOG) || (echo "simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb_irq_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_irq_subsystem
    import irq_pkg::*;
();

    localparam int N_EXT      = 4;
    localparam int CYCLE_NS   = 8;
    localparam int MAX_TRANS  = 200;
    localparam int TRANS_CYC  = 20;  // cycles allowed for one transaction

    localparam addr_t CLAIM_ADDR   = PLIC_BASE + addr_t'(PLIC_CLAIM_OFS);
    localparam addr_t PENDING_ADDR = PLIC_BASE + addr_t'(PLIC_PENDING_OFS);
    localparam addr_t ENABLE_ADDR  = PLIC_BASE + addr_t'(PLIC_ENABLE_OFS);
    localparam addr_t PERIOD_ADDR  = TIMER_BASE + addr_t'(TIMER_PERIOD_OFS);
    localparam addr_t CTRL_ADDR    = TIMER_BASE + addr_t'(TIMER_CTRL_OFS);

    logic             clk;
    logic             reset;
    logic             req_valid_i;
    logic             req_ready_o;
    addr_t            req_addr_i;
    strb_t            req_we_i;
    data_t            req_wdata_i;
    logic             rsp_valid_o;
    logic             rsp_ready_i;
    data_t            rsp_rdata_o;
    logic [N_EXT-1:0] ext_irq_i;
    logic             irq_o;
    logic             iack_i;
    logic [N_EXT-1:0] ext_iack_o;

    integer           seed = 32'hbfd0f400;
    int               errors;
    int               checks;
    logic [N_EXT+1:1] ie_model;      // enable bits, source 1 in the lowest bit
    logic [N_EXT-1:0] ext_model;     // levels on the external pins
    data_t            period_model;

    irq_subsystem #(
        .N_EXT (N_EXT)
    ) irq_subsystem_inst (
        .clk         (clk),
        .reset       (reset),
        .req_valid_i (req_valid_i),
        .req_ready_o (req_ready_o),
        .req_addr_i  (req_addr_i),
        .req_we_i    (req_we_i),
        .req_wdata_i (req_wdata_i),
        .rsp_valid_o (rsp_valid_o),
        .rsp_ready_i (rsp_ready_i),
        .rsp_rdata_o (rsp_rdata_o),
        .ext_irq_i   (ext_irq_i),
        .irq_o       (irq_o),
        .iack_i      (iack_i),
        .ext_iack_o  (ext_iack_o)
    );

    initial clk = 1'b0;
    always #(CYCLE_NS / 2) clk = ~clk;

    // the whole run must fit the transaction budget
    initial begin
        #(MAX_TRANS * TRANS_CYC * CYCLE_NS);
        $display("watchdog expired at %0t ns, the test sequence did not finish", $time);
        $display("*** TEST FAILED ***");
        $finish;
    end

    // ==========================================================
    // helpers, all called right after a rising edge
    // ==========================================================
    task automatic check_value(input string what, input data_t got, input data_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic run_access(input addr_t addr, input strb_t we, input data_t wdata,
                              output data_t rdata);
        int    hold;
        int    waited;
        logic  taken;
        data_t first;
        hold = $unsigned($random(seed)) % 4;  // extra cycles of response back-pressure
        req_valid_i <= 1'b1;
        req_addr_i  <= addr;
        req_we_i    <= we;
        req_wdata_i <= wdata;
        waited = 0;
        taken  = 1'b0;
        first  = '0;
        rdata  = '0;
        while (!taken && waited < TRANS_CYC) begin
            @(negedge clk);
            taken = req_ready_o;
            @(posedge clk);
            waited++;
        end
        req_valid_i <= 1'b0;
        if (!taken) begin
            errors++;
            $display("request to address %h was never accepted", addr);
            return;
        end
        rsp_ready_i <= (hold == 0);
        for (int c = 0; c <= hold; c++) begin
            @(negedge clk);
            if (c == 0) begin
                first = rsp_rdata_o;
            end
            if (rsp_valid_o !== 1'b1 || rsp_rdata_o !== first || req_ready_o !== 1'b0) begin
                errors++;
                $display("[FAIL] %0t ns: response to %h not held steady", $time, addr);
            end
            @(posedge clk);
            rsp_ready_i <= (c + 1 == hold);  // the response transfers on the edge after c == hold
        end
        rdata = first;
    endtask

    task automatic write_reg(input addr_t addr, input data_t wdata);
        data_t unused;
        run_access(addr, 4'hf, wdata, unused);
    endtask

    task automatic read_reg(input addr_t addr, output data_t rdata);
        run_access(addr, 4'h0, '0, rdata);
    endtask

    task automatic set_ext_levels(input logic [N_EXT-1:0] levels);
        ext_irq_i <= levels;
        ext_model = levels;
        repeat (4) @(posedge clk);  // two sync stages plus the pending register
    endtask

    // one-cycle acknowledge, sampling the grant and the request line in that cycle
    task automatic acknowledge(output logic [N_EXT-1:0] grant, output logic req_seen);
        iack_i <= 1'b1;
        @(negedge clk);
        grant    = ext_iack_o;
        req_seen = irq_o;
        @(posedge clk);
        iack_i <= 1'b0;
    endtask

    function automatic int lowest_active(input logic [N_EXT+1:1] active);
        int id;
        id = 0;
        for (int k = 1; k <= N_EXT + 1; k++) begin
            if (active[k] && id == 0) begin
                id = k;
            end
        end
        return id;
    endfunction

    // ==========================================================
    // test sequence
    // ==========================================================
    initial begin : main
        data_t            rd;
        data_t            val;
        addr_t            bad_addr;
        logic [11:0]      region;
        logic [N_EXT+1:1] pend;
        logic [N_EXT-1:0] grant;
        logic [N_EXT-1:0] exp_grant;
        logic             req_seen;
        int               winner;
        int unsigned      period;
        reset       = 1'b1;
        req_valid_i = 1'b0;
        req_addr_i  = '0;
        req_we_i    = '0;
        req_wdata_i = '0;
        rsp_ready_i = 1'b0;
        ext_irq_i   = '0;
        iack_i      = 1'b0;
        errors       = 0;
        checks       = 0;
        ie_model     = '0;
        ext_model    = '0;
        period_model = '0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);

        // everything idle out of reset
        @(negedge clk);
        check_value("irq_o after reset", data_t'(irq_o), '0);
        check_value("ext_iack_o after reset", data_t'(ext_iack_o), '0);
        check_value("req_ready_o after reset", data_t'(req_ready_o), 32'h1);
        @(posedge clk);
        read_reg(CLAIM_ADDR, rd);
        check_value("claim after reset", rd, '0);
        read_reg(PENDING_ADDR, rd);
        check_value("pending after reset", rd, '0);
        read_reg(ENABLE_ADDR, rd);
        check_value("enable after reset", rd, '0);

        repeat (16) begin
            val = $random(seed);
            write_reg(ENABLE_ADDR, val);
            ie_model = val[N_EXT+1:1];
            read_reg(ENABLE_ADDR, rd);
            check_value("enable readback", rd, data_t'({ie_model, 1'b0}));
        end

        // level sources with the timer still idle
        repeat (16) begin
            val = $random(seed);
            write_reg(ENABLE_ADDR, val);
            ie_model = val[N_EXT+1:1];
            val = $random(seed);
            set_ext_levels(val[N_EXT-1:0]);
            pend = {ext_model, 1'b0};
            read_reg(PENDING_ADDR, rd);
            check_value("pending readback", rd, data_t'({pend, 1'b0}));
            @(negedge clk);
            check_value("irq_o", data_t'(irq_o), data_t'(|(pend & ie_model)));
            @(posedge clk);
        end

        repeat (16) begin
            val = $random(seed);
            write_reg(ENABLE_ADDR, val);
            ie_model = val[N_EXT+1:1];
            val = $random(seed);
            set_ext_levels(val[N_EXT-1:0]);
            winner = lowest_active({ext_model, 1'b0} & ie_model);
            exp_grant = '0;
            if (winner >= 2) begin
                exp_grant = N_EXT'(1) << (winner - 2);
            end
            acknowledge(grant, req_seen);
            check_value("ext_iack_o on acknowledge", data_t'(grant), data_t'(exp_grant));
            check_value("irq_o during acknowledge", data_t'(req_seen), '0);
            read_reg(CLAIM_ADDR, rd);
            check_value("claim after acknowledge", rd, data_t'(winner));
        end

        // ==========================================================
        // timer, only source 1 enabled
        // ==========================================================
        set_ext_levels('0);
        write_reg(ENABLE_ADDR, 32'h2);
        ie_model = '0;
        ie_model[TIMER_SRC_ID] = 1'b1;
        repeat (3) begin
            period = 5 + ($unsigned($random(seed)) % 36);
            period_model = data_t'(period);
            write_reg(PERIOD_ADDR, period_model);
            write_reg(CTRL_ADDR, 32'h1);
            repeat (period + 10) @(posedge clk);
            write_reg(CTRL_ADDR, 32'h0);  // stop it so no second expiry follows the acknowledge
            read_reg(CTRL_ADDR, rd);
            check_value("timer control after expiry", rd, 32'h2);
            read_reg(PENDING_ADDR, rd);
            check_value("pending with timer fired", rd, 32'h2);
            @(negedge clk);
            check_value("irq_o with timer fired", data_t'(irq_o), 32'h1);
            @(posedge clk);
            acknowledge(grant, req_seen);
            check_value("ext_iack_o on timer acknowledge", data_t'(grant), '0);
            check_value("irq_o during timer acknowledge", data_t'(req_seen), '0);
            repeat (3) @(posedge clk);
            read_reg(PENDING_ADDR, rd);
            check_value("pending after timer acknowledge", rd, '0);
            read_reg(CLAIM_ADDR, rd);
            check_value("claim after timer acknowledge", rd, data_t'(TIMER_SRC_ID));
            repeat (period + 10) @(posedge clk);  // a stopped timer stays quiet
            read_reg(PENDING_ADDR, rd);
            check_value("pending with timer disabled", rd, '0);
            read_reg(PERIOD_ADDR, rd);
            check_value("timer period readback", rd, period_model);
        end

        // addresses above both regions, at the offsets where registers live
        repeat (10) begin
            val = $random(seed);
            region = 12'(2 + ($unsigned($random(seed)) % 4094));
            bad_addr = {region, 8'h00, val[3:2], 2'b00};
            read_reg(bad_addr, rd);
            check_value("unmapped read", rd, '0);
            write_reg(bad_addr, $random(seed));
            read_reg(ENABLE_ADDR, rd);
            check_value("enable after unmapped write", rd, data_t'({ie_model, 1'b0}));
            read_reg(PERIOD_ADDR, rd);
            check_value("period after unmapped write", rd, period_model);
        end

        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end
        else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== irq_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module irq_subsystem
    import irq_pkg::*;
#(
    parameter int unsigned N_EXT = 4
) (
    input  logic             clk,
    input  logic             reset,
    // host request
    input  logic             req_valid_i,
    output logic             req_ready_o,
    input  addr_t            req_addr_i,
    input  strb_t            req_we_i,
    input  data_t            req_wdata_i,
    // host response
    output logic             rsp_valid_o,
    input  logic             rsp_ready_i,
    output data_t            rsp_rdata_o,
    // interrupt side, external bit 0 is source 2
    input  logic [N_EXT-1:0] ext_irq_i,
    output logic             irq_o,
    input  logic             iack_i,
    output logic [N_EXT-1:0] ext_iack_o
);

    logic [N_EXT-1:0] ext_sync;
    logic             timer_irq;
    logic [N_EXT+1:1] src_irq;
    logic [N_EXT+1:1] src_iack;

    periph_bus_if plic_bus ();
    periph_bus_if timer_bus ();

    // ==========================================================
    // source vector, timer first and external lines above it
    // ==========================================================
    assign src_irq[TIMER_SRC_ID]             = timer_irq;
    assign src_irq[N_EXT+1:TIMER_SRC_ID+1]   = ext_sync;
    assign ext_iack_o = src_iack[N_EXT+1:TIMER_SRC_ID+1];

    mmio_bridge bridge_inst (
        .clk         (clk),
        .reset       (reset),
        .req_valid_i (req_valid_i),
        .req_ready_o (req_ready_o),
        .req_addr_i  (req_addr_i),
        .req_we_i    (req_we_i),
        .req_wdata_i (req_wdata_i),
        .rsp_valid_o (rsp_valid_o),
        .rsp_ready_i (rsp_ready_i),
        .rsp_rdata_o (rsp_rdata_o),
        .plic_bus    (plic_bus.master),
        .timer_bus   (timer_bus.master)
    );

    irq_sync #(
        .WIDTH (N_EXT)
    ) sync_inst (
        .clk     (clk),
        .reset   (reset),
        .async_i (ext_irq_i),
        .sync_o  (ext_sync)
    );

    irq_timer timer_inst (
        .clk    (clk),
        .reset  (reset),
        .iack_i (src_iack[TIMER_SRC_ID]),
        .irq_o  (timer_irq),
        .bus    (timer_bus.slave)
    );

    plic #(
        .SRC_CNT (N_EXT + 1)
    ) plic_inst (
        .clk    (clk),
        .reset  (reset),
        .irq_i  (src_irq),
        .iack_i (iack_i),
        .irq_o  (irq_o),
        .iack_o (src_iack),
        .bus    (plic_bus.slave)
    );

endmodule

`default_nettype wire

// ==== mmio_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

module mmio_bridge
    import irq_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  logic          req_valid_i,
    output logic          req_ready_o,
    input  addr_t         req_addr_i,
    input  strb_t         req_we_i,
    input  data_t         req_wdata_i,
    output logic          rsp_valid_o,
    input  logic          rsp_ready_i,
    output data_t         rsp_rdata_o,
    periph_bus_if.master  plic_bus,
    periph_bus_if.master  timer_bus
);

    logic hit_plic;
    logic hit_timer;
    logic accept;
    logic rsp_valid_q;
    logic rd_q;         // the held response belongs to a read
    logic sel_plic_q;
    logic sel_timer_q;

    // ==========================================================
    // decode and strobe
    // ==========================================================
    assign hit_plic  = (req_addr_i[23:12] == PLIC_BASE[23:12]);
    assign hit_timer = (req_addr_i[23:12] == TIMER_BASE[23:12]);

    assign req_ready_o = ~rsp_valid_q;  // one access in flight at most
    assign accept      = req_valid_i & req_ready_o;

    assign plic_bus.en    = accept & hit_plic;
    assign plic_bus.we    = req_we_i;
    assign plic_bus.addr  = req_addr_i;
    assign plic_bus.wdata = req_wdata_i;

    assign timer_bus.en    = accept & hit_timer;
    assign timer_bus.we    = req_we_i;
    assign timer_bus.addr  = req_addr_i;
    assign timer_bus.wdata = req_wdata_i;

    // ==========================================================
    // response hold
    // ==========================================================
    always_ff @(posedge clk) begin
        if (reset == 1'b1) begin
            rsp_valid_q <= 1'b0;
            rd_q        <= 1'b0;
            sel_plic_q  <= 1'b0;
            sel_timer_q <= 1'b0;
        end
        else if (accept) begin
            rsp_valid_q <= 1'b1;
            rd_q        <= (req_we_i == '0);
            sel_plic_q  <= hit_plic;
            sel_timer_q <= hit_timer;
        end
        else if (rsp_ready_i) begin
            rsp_valid_q <= 1'b0;
        end
    end

    assign rsp_valid_o = rsp_valid_q;

    // the slaves keep rdata until their next read, which cannot come while held
    always_comb begin
        rsp_rdata_o = '0;
        if (rd_q && sel_plic_q) begin
            rsp_rdata_o = plic_bus.rdata;
        end
        else if (rd_q && sel_timer_q) begin
            rsp_rdata_o = timer_bus.rdata;
        end
    end

    a_no_accept_held: assert property (@(posedge clk) disable iff (reset)
        rsp_valid_o |-> !(plic_bus.en || timer_bus.en));

    a_rsp_stable: assert property (@(posedge clk) disable iff (reset)
        (rsp_valid_o && !rsp_ready_i) |=> (rsp_valid_o && $stable(rsp_rdata_o)));

endmodule

`default_nettype wire

// ==== plic.sv ====
`timescale 1ns/1ps
`default_nettype none

module plic
    import irq_pkg::*;
#(
    parameter int unsigned SRC_CNT = 5
) (
    input  logic               clk,
    input  logic               reset,
    input  logic [SRC_CNT:1]   irq_i,  // source 1 in the lowest bit
    input  logic               iack_i,
    output logic               irq_o,
    output logic [SRC_CNT:1]   iack_o,
    periph_bus_if.slave        bus
);

    // wide enough for every source number plus the zero for none
    localparam int unsigned ID_W = $clog2(SRC_CNT + 1);

    logic [SRC_CNT:1] ip_q;       // pending, level sampled
    logic [SRC_CNT:1] ie_q;       // enable
    logic [SRC_CNT:1] active;
    logic [SRC_CNT:1] winner_oh;
    logic [ID_W-1:0]  winner_id;
    logic [ID_W-1:0]  claim_q;
    data_t            rd_word;

    if (SRC_CNT > MAX_SOURCES) begin : g_src_check
        $error("plic: SRC_CNT does not fit the data word");
    end

    // ==========================================================
    // pending sampling and source selection
    // ==========================================================
    always_ff @(posedge clk) begin
        if (reset == 1'b1) begin
            ip_q <= '0;
        end
        else begin
            ip_q <= irq_i;
        end
    end

    assign active    = ip_q & ie_q;
    assign winner_oh = active & (~active + 1'b1);  // isolates the lowest set bit

    // walk down so that the lowest-numbered source is assigned last
    always_comb begin
        winner_id = '0;
        for (int i = SRC_CNT; i >= 1; i--) begin
            if (active[i]) begin
                winner_id = ID_W'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset == 1'b1) begin
            claim_q <= '0;
        end
        else if (iack_i) begin
            claim_q <= winner_id;
        end
    end

    assign irq_o  = (|active) & ~iack_i;
    assign iack_o = iack_i ? winner_oh : '0;

    // ==========================================================
    // register access
    // ==========================================================
    always_ff @(posedge clk) begin
        if (reset == 1'b1) begin
            ie_q <= '0;
        end
        else if (bus.en && (bus.we != '0) && (bus.addr[11:0] == PLIC_ENABLE_OFS)) begin
            ie_q <= bus.wdata[SRC_CNT:1];
        end
    end

    // bit k of pending and enable reads as source k, bit 0 stays zero
    always_comb begin
        rd_word = '0;
        case (bus.addr[11:0])
            PLIC_CLAIM_OFS:   rd_word[ID_W-1:0] = claim_q;
            PLIC_PENDING_OFS: rd_word[SRC_CNT:1] = ip_q;
            PLIC_ENABLE_OFS:  rd_word[SRC_CNT:1] = ie_q;
            default:          ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (bus.en && (bus.we == '0)) begin
            bus.rdata <= rd_word;
        end
    end

    a_iack_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0(iack_o));

    a_iack_gated: assert property (@(posedge clk) disable iff (reset)
        !iack_i |-> (iack_o == '0));

endmodule

`default_nettype wire

// ==== irq_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module irq_timer
    import irq_pkg::*;
(
    input  logic               clk,
    input  logic               reset,
    input  logic               iack_i,
    output logic               irq_o,
    periph_bus_if.slave        bus
);

    data_t period_q;
    data_t count_q;
    logic  enable_q;
    logic  fired_q;
    logic  wr;
    logic  rd;
    logic  ctrl_wr;
    data_t rd_word;

    assign wr      = bus.en && (bus.we != '0);
    assign rd      = bus.en && (bus.we == '0);
    assign ctrl_wr = wr && (bus.addr[11:0] == TIMER_CTRL_OFS);

    // ==========================================================
    // programmable registers
    // ==========================================================
    always_ff @(posedge clk) begin
        if (reset == 1'b1) begin
            period_q <= '0;
            enable_q <= 1'b0;
        end
        else if (wr) begin
            if (bus.addr[11:0] == TIMER_PERIOD_OFS) begin
                period_q <= bus.wdata;
            end
            if (ctrl_wr) begin
                enable_q <= bus.wdata[0];
            end
        end
    end

    // ==========================================================
    // counter and interrupt flag
    // ==========================================================
    always_ff @(posedge clk) begin
        if (reset == 1'b1) begin
            count_q <= '0;
            fired_q <= 1'b0;
        end
        else begin
            if (iack_i) begin
                fired_q <= 1'b0;  // a new expiry below still wins
            end
            if (ctrl_wr) begin
                count_q <= '0;  // reprogramming restarts the interval
            end
            else if (enable_q && (period_q != '0)) begin
                if (count_q >= period_q - 1'b1) begin
                    count_q <= '0;
                    fired_q <= 1'b1;
                end
                else begin
                    count_q <= count_q + 1'b1;
                end
            end
        end
    end

    assign irq_o = fired_q;  // level until acknowledged

    always_comb begin
        rd_word = '0;
        case (bus.addr[11:0])
            TIMER_PERIOD_OFS: rd_word = period_q;
            TIMER_CTRL_OFS:   rd_word[1:0] = {fired_q, enable_q};
            TIMER_COUNT_OFS:  rd_word = count_q;
            default:          ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rd) begin
            bus.rdata <= rd_word;
        end
    end

    // a disabled timer must stay silent
    a_no_fire_disabled: assert property (@(posedge clk) disable iff (reset)
        $rose(irq_o) |-> enable_q);

endmodule

`default_nettype wire

// ==== irq_sync.sv ====
`timescale 1ns/1ps
`default_nettype none

module irq_sync #(
    parameter int unsigned WIDTH = 1
) (
    input  logic             clk,
    input  logic             reset,
    input  logic [WIDTH-1:0] async_i,
    output logic [WIDTH-1:0] sync_o
);

    // each line is independent, so no bus coherency is implied
    logic [WIDTH-1:0] meta_q;
    logic [WIDTH-1:0] sync_q;

    // ==========================================================
    // two flops per line
    // ==========================================================
    always_ff @(posedge clk) begin
        if (reset == 1'b1) begin
            meta_q <= '0;
            sync_q <= '0;
        end
        else begin
            meta_q <= async_i;  // may go metastable
            sync_q <= meta_q;   // settled by the second edge
        end
    end

    assign sync_o = sync_q;

endmodule

`default_nettype wire

// ==== periph_bus_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// single-cycle register access from the bridge to one peripheral
interface periph_bus_if
    import irq_pkg::*;
();

    logic  en;     // one-cycle access strobe
    strb_t we;     // zero for a read
    addr_t addr;
    data_t wdata;
    data_t rdata;  // held by the slave until its next read

    modport master (
        output en,
        output we,
        output addr,
        output wdata,
        input  rdata
    );

    modport slave (
        input  en,
        input  we,
        input  addr,
        input  wdata,
        output rdata
    );

endinterface

`default_nettype wire

// ==== irq_pkg.sv ====
`default_nettype none

package irq_pkg;

    // ==========================================================
    // bus widths
    // ==========================================================
    typedef logic [23:0] addr_t;  // byte address on the host bus
    typedef logic [31:0] data_t;  // one register word
    typedef logic [3:0]  strb_t;  // any nonzero strobe writes the whole register
    typedef logic [11:0] ofs_t;   // register offset inside a 4 KiB region

    // one bit per source above bit 0 of a data word
    localparam int unsigned MAX_SOURCES = 31;

    // ==========================================================
    // memory map, the region is picked by address bits 23 to 12
    // ==========================================================
    localparam addr_t PLIC_BASE  = 24'h000000;
    localparam addr_t TIMER_BASE = 24'h001000;

    localparam ofs_t PLIC_CLAIM_OFS   = 12'h000;
    localparam ofs_t PLIC_PENDING_OFS = 12'h004;
    localparam ofs_t PLIC_ENABLE_OFS  = 12'h008;

    localparam ofs_t TIMER_PERIOD_OFS = 12'h000;
    localparam ofs_t TIMER_CTRL_OFS   = 12'h004;
    localparam ofs_t TIMER_COUNT_OFS  = 12'h008;

    // the timer sits below the external lines in the source vector
    localparam int unsigned TIMER_SRC_ID = 1;

endpackage

`default_nettype wire
